//--- vlog.f
logic/matmul_pkg.sv
logic/job_if.sv
logic/job_intake.sv
logic/a_strip_issuer.sv
logic/b_strip_issuer.sv
logic/tile_writer_issuer.sv
logic/completion_tracker.sv
logic/matmul_controller.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_matmul_controller.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_matmul_controller -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -qx "TESTBENCH PASSED"

//--- dv/tb_matmul_controller.sv
/*
 * Testbench top for the matmul job controller
 * Operand buffers take strips with random ready, C writers accept tiles with
 * random ready and report completions only after the strips a tile needs arrived
 * Runs a job with L=16, then one with L=8
 */
`timescale 1ns/100ps

module tb_matmul_controller;
  import matmul_pkg::*;

  localparam int N    = 4;
  localparam int ROWS = 2;
  localparam int COLS = 2;
  localparam int P    = ROWS * COLS;

  logic              clk;
  logic              reset;
  logic              job_valid = 1'b0;
  logic              job_ready;
  addr_t             a_addr = '0;
  addr_t             b_addr = '0;
  addr_t             c_addr = '0;
  len_t              matrix_len = '0;
  logic              done;
  logic [ROWS-1:0]   a_valid;
  logic [ROWS-1:0]   a_ready = '0;
  addr_t [ROWS-1:0]  a_strip_addr;
  count_t [ROWS-1:0] a_repeats;
  len_t              a_len;
  logic [COLS-1:0]   b_valid;
  logic [COLS-1:0]   b_ready = '0;
  addr_t [COLS-1:0]  b_strip_addr;
  len_t              b_len;
  logic [P-1:0]      c_valid;
  logic [P-1:0]      c_ready = '0;
  addr_t [P-1:0]     c_tile_addr;
  logic [P-1:0]      cpl_valid = '0;
  logic [P-1:0]      cpl_ready;
  int                check_errors;
  int                timeouts = 0;
  int                cur_len = 0;

  // Downstream model counts of items received and completions sent per lane
  int a_got[ROWS];
  int b_got[COLS];
  int c_got[P];
  int cpl_sent[P];
  int cpl_delay[P];

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clock (.clk, .reset);

  matmul_controller #(.N(N), .ROWS(ROWS), .COLS(COLS)) DUT (.*);

  tb_checker #(.N(N), .ROWS(ROWS), .COLS(COLS)) u_checker (.*, .errors(check_errors));

  // Buffers and writers sample on the edge and drive 1 ns later
  initial begin : model_lanes
    int           tcols;
    logic [P-1:0] cpl_hs;
    void'($urandom(32'h3018));
    forever begin
      @(posedge clk);
      cpl_hs = cpl_valid & cpl_ready;
      for (int r = 0; r < ROWS; r++) begin
        if (job_valid && job_ready) begin
          a_got[r] = 0;
        end else if (a_valid[r] && a_ready[r]) begin
          a_got[r]++;
        end
      end
      for (int c = 0; c < COLS; c++) begin
        if (job_valid && job_ready) begin
          b_got[c] = 0;
        end else if (b_valid[c] && b_ready[c]) begin
          b_got[c]++;
        end
      end
      for (int p = 0; p < P; p++) begin
        if (job_valid && job_ready) begin
          c_got[p]    = 0;
          cpl_sent[p] = 0;
        end else begin
          c_got[p]    += int'(c_valid[p] && c_ready[p]);
          cpl_sent[p] += int'(cpl_hs[p]);
        end
      end
      #1;
      a_ready = ROWS'($urandom);
      b_ready = COLS'($urandom);
      c_ready = P'($urandom);
      tcols = (cur_len / N) / COLS;
      if (tcols == 0) begin
        tcols = 1;
      end
      for (int p = 0; p < P; p++) begin
        // A raised completion holds until the controller takes it
        if (!cpl_valid[p] || cpl_hs[p]) begin
          // Tile n needs B item n of its column and A strip n/(T/COLS) of its row
          if (c_got[p] > cpl_sent[p] && b_got[p % COLS] > cpl_sent[p] &&
              a_got[p / COLS] > cpl_sent[p] / tcols && cpl_delay[p] == 0) begin
            cpl_valid[p] = 1'b1;
            cpl_delay[p] = $urandom_range(3, 0);
          end else begin
            cpl_valid[p] = 1'b0;
            if (cpl_delay[p] > 0) begin
              cpl_delay[p]--;
            end
          end
        end
      end
    end
  end

  // Presents one job and waits until done rises
  task automatic run_job(input addr_t a, input addr_t b, input addr_t c, input int len);
    int cycles;
    #1;
    a_addr     = a;
    b_addr     = b;
    c_addr     = c;
    matrix_len = len_t'(len);
    cur_len    = len;
    job_valid  = 1'b1;
    cycles     = 1;
    @(posedge clk);
    while (!job_ready && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    if (!job_ready) begin
      timeouts++;
      $display("Timeout: the job with L=%0d was never accepted", len);
    end
    #1 job_valid = 1'b0;
    cycles = 0;
    while (!done && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout: done never rose for the job with L=%0d", len);
    end
  endtask

  initial begin : stimulus
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (reset && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (reset) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    run_job(32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 16);
    run_job(32'h0004_0000, 32'h0005_8000, 32'h0007_0000, 8);
    // Idle tail where done must hold
    repeat (3) @(posedge clk);
    $display("Errors: compare %0d, timeout %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- dv/tb_checker.sv
/*
 * Watches the controller ports on every rising edge and compares each lane
 * transfer with the tiling rules, and job_ready, done and cpl_ready with a job model
 * Inputs are assumed to change 1 ns after the edge
 */
`timescale 1ns/100ps

module tb_checker #(
  parameter int N    = 4,
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              job_valid,
  input  logic                              job_ready,
  input  matmul_pkg::addr_t                 a_addr,
  input  matmul_pkg::addr_t                 b_addr,
  input  matmul_pkg::addr_t                 c_addr,
  input  matmul_pkg::len_t                  matrix_len,
  input  logic                              done,
  input  logic [ROWS-1:0]                   a_valid,
  input  logic [ROWS-1:0]                   a_ready,
  input  matmul_pkg::addr_t [ROWS-1:0]      a_strip_addr,
  input  matmul_pkg::count_t [ROWS-1:0]     a_repeats,
  input  matmul_pkg::len_t                  a_len,
  input  logic [COLS-1:0]                   b_valid,
  input  logic [COLS-1:0]                   b_ready,
  input  matmul_pkg::addr_t [COLS-1:0]      b_strip_addr,
  input  matmul_pkg::len_t                  b_len,
  input  logic [ROWS*COLS-1:0]              c_valid,
  input  logic [ROWS*COLS-1:0]              c_ready,
  input  matmul_pkg::addr_t [ROWS*COLS-1:0] c_tile_addr,
  input  logic [ROWS*COLS-1:0]              cpl_valid,
  input  logic [ROWS*COLS-1:0]              cpl_ready,
  output int                                errors
);
  import matmul_pkg::*;

  localparam int P = ROWS * COLS;

  // Latched job
  addr_t job_a;
  addr_t job_b;
  addr_t job_c;
  int    job_len = 0;
  int    job_num = 0;
  // Job state as the controller should see it
  logic  exp_active = 1'b0;
  logic  exp_done = 1'b0;
  logic  reset_checked = 1'b0;
  int    err_count = 0;
  int    cpl_total = 0;
  // Items seen so far, per lane
  int    a_idx[ROWS];
  int    b_idx[COLS];
  int    c_idx[P];
  int    cpl_idx[P];

  assign errors = err_count;

  // T, tiles along one side
  function automatic int tiles_per_side();
    return job_len / N;
  endfunction

  function automatic int a_items();
    return tiles_per_side() / ROWS;
  endfunction

  // T/COLS, also the inner sweep length of B and C lanes
  function automatic int exp_repeats();
    return tiles_per_side() / COLS;
  endfunction

  function automatic int lane_items();
    return a_items() * exp_repeats();
  endfunction

  function automatic addr_t exp_a_addr(int r, int k);
    return job_a + addr_t'((k * ROWS + r) * N * job_len);
  endfunction

  function automatic addr_t exp_b_addr(int c, int k);
    int jj;
    jj = k % exp_repeats();
    return job_b + addr_t'((jj * COLS + c) * N * job_len);
  endfunction

  function automatic addr_t exp_c_addr(int p, int k);
    int i;
    int j;
    i = (k / exp_repeats()) * ROWS + p / COLS;
    j = (k % exp_repeats()) * COLS + p % COLS;
    return job_c + addr_t'((i * tiles_per_side() + j) * N * N);
  endfunction

  task automatic check_value(string name, longint expected, longint actual);
    if (expected != actual) begin
      err_count++;
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic check_item(string lane, int idx, int count, addr_t expected, addr_t actual);
    if (idx >= count) begin
      err_count++;
      $display("Job %0d: lane %s issued more than its %0d items", job_num, lane, count);
    end else begin
      check_value($sformatf("job%0d_%s_item%0d", job_num, lane, idx), expected, actual);
    end
  endtask

  task automatic start_job();
    job_num++;
    job_a      = a_addr;
    job_b      = b_addr;
    job_c      = c_addr;
    job_len    = int'(matrix_len);
    exp_active = 1'b1;
    exp_done   = 1'b0;
    cpl_total  = 0;
    for (int r = 0; r < ROWS; r++) begin
      a_idx[r] = 0;
    end
    for (int c = 0; c < COLS; c++) begin
      b_idx[c] = 0;
    end
    for (int p = 0; p < P; p++) begin
      c_idx[p]   = 0;
      cpl_idx[p] = 0;
    end
  endtask

  // Last completion seen, every lane must have delivered its full count
  task automatic end_job();
    exp_active = 1'b0;
    exp_done   = 1'b1;
    for (int r = 0; r < ROWS; r++) begin
      check_value($sformatf("job%0d_a%0d_count", job_num, r), a_items(), a_idx[r]);
    end
    for (int c = 0; c < COLS; c++) begin
      check_value($sformatf("job%0d_b%0d_count", job_num, c), lane_items(), b_idx[c]);
    end
    for (int p = 0; p < P; p++) begin
      check_value($sformatf("job%0d_c%0d_count", job_num, p), lane_items(), c_idx[p]);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      exp_active = 1'b0;
      exp_done   = 1'b0;
    end else begin
      if (!reset_checked) begin
        // First edge out of reset
        reset_checked = 1'b1;
        check_value("reset_job_ready", 1, job_ready);
        check_value("reset_valids", 0, {a_valid, b_valid, c_valid});
        check_value("reset_cpl_ready", 0, cpl_ready);
      end
      // Status against the model, before this edge updates it
      check_value($sformatf("job%0d_job_ready", job_num), !exp_active, job_ready);
      check_value($sformatf("job%0d_done", job_num), exp_done, done);
      for (int p = 0; p < P; p++) begin
        check_value($sformatf("job%0d_cpl_ready%0d", job_num, p),
                    exp_active && (cpl_idx[p] < lane_items()), cpl_ready[p]);
      end
      if (job_valid && job_ready) begin
        start_job();
      end
      for (int r = 0; r < ROWS; r++) begin
        if (a_valid[r] && a_ready[r]) begin
          check_item($sformatf("a%0d", r), a_idx[r], a_items(), exp_a_addr(r, a_idx[r]),
                     a_strip_addr[r]);
          check_value($sformatf("job%0d_a%0d_repeats", job_num, r), exp_repeats(),
                      a_repeats[r]);
          check_value($sformatf("job%0d_a%0d_len", job_num, r), job_len, a_len);
          a_idx[r]++;
        end
      end
      for (int c = 0; c < COLS; c++) begin
        if (b_valid[c] && b_ready[c]) begin
          check_item($sformatf("b%0d", c), b_idx[c], lane_items(), exp_b_addr(c, b_idx[c]),
                     b_strip_addr[c]);
          check_value($sformatf("job%0d_b%0d_len", job_num, c), job_len, b_len);
          b_idx[c]++;
        end
      end
      for (int p = 0; p < P; p++) begin
        if (c_valid[p] && c_ready[p]) begin
          check_item($sformatf("c%0d", p), c_idx[p], lane_items(), exp_c_addr(p, c_idx[p]),
                     c_tile_addr[p]);
          c_idx[p]++;
        end
        if (cpl_valid[p] && cpl_ready[p]) begin
          cpl_idx[p]++;
          cpl_total++;
        end
      end
      if (exp_active && cpl_total == P * lane_items()) begin
        end_job();
      end
    end
  end

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Free-running clock, and a synchronous reset held for RESET_CYCLES rising edges
 * Reset is released 1 ns after its last edge, like every other input
 */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- logic/matmul_controller.sv
/*
 * Job controller of the tiled matmul accelerator, top level
 * All lanes are valid/ready, valid holds until its transfer
 * L must be a nonzero multiple of N*ROWS and N*COLS, at most MAX_LEN
 * c_* and cpl_* lane p serves processor p = r*COLS + c
 */
`timescale 1ns/100ps

module matmul_controller #(
  parameter int N    = 4,
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                               clk,
  input  logic                               reset,
  // Job
  input  logic                               job_valid,
  output logic                               job_ready,
  input  matmul_pkg::addr_t                  a_addr,
  input  matmul_pkg::addr_t                  b_addr,
  input  matmul_pkg::addr_t                  c_addr,
  input  matmul_pkg::len_t                   matrix_len,
  output logic                               done,
  // A strips, per processor row
  output logic [ROWS-1:0]                    a_valid,
  input  logic [ROWS-1:0]                    a_ready,
  output matmul_pkg::addr_t [ROWS-1:0]       a_strip_addr,
  output matmul_pkg::count_t [ROWS-1:0]      a_repeats,
  output matmul_pkg::len_t                   a_len,
  // B strips, per processor column
  output logic [COLS-1:0]                    b_valid,
  input  logic [COLS-1:0]                    b_ready,
  output matmul_pkg::addr_t [COLS-1:0]       b_strip_addr,
  output matmul_pkg::len_t                   b_len,
  // C tiles and completions, per processor
  output logic [ROWS*COLS-1:0]               c_valid,
  input  logic [ROWS*COLS-1:0]               c_ready,
  output matmul_pkg::addr_t [ROWS*COLS-1:0]  c_tile_addr,
  input  logic [ROWS*COLS-1:0]               cpl_valid,
  output logic [ROWS*COLS-1:0]               cpl_ready
);

  job_if job_bus ();

  job_intake u_intake (
    .clk, .reset, .job_valid, .job_ready, .a_addr, .b_addr, .c_addr, .matrix_len, .done,
    .job (job_bus.intake)
  );

  a_strip_issuer #(.N(N), .ROWS(ROWS), .COLS(COLS)) u_a_issuer (
    .clk, .reset, .job (job_bus.issuer), .a_valid, .a_ready, .a_strip_addr, .a_repeats, .a_len
  );

  b_strip_issuer #(.N(N), .ROWS(ROWS), .COLS(COLS)) u_b_issuer (
    .clk, .reset, .job (job_bus.issuer), .b_valid, .b_ready, .b_strip_addr, .b_len
  );

  tile_writer_issuer #(.N(N), .ROWS(ROWS), .COLS(COLS)) u_c_issuer (
    .clk, .reset, .job (job_bus.issuer), .c_valid, .c_ready, .c_tile_addr
  );

  completion_tracker #(.ROWS(ROWS), .COLS(COLS), .N(N)) u_tracker (
    .clk, .reset, .job (job_bus.tracker), .cpl_valid, .cpl_ready
  );

endmodule

//--- logic/completion_tracker.sv
/*
 * Completion counting, one counter per C tile writer
 * all_done rises on the cycle of the last completion handshake
 * Counters clear while no job is active
 */
`timescale 1ns/100ps

module completion_tracker #(
  parameter int ROWS = 2,
  parameter int COLS = 2,
  parameter int N    = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  job_if.tracker               job,
  input  logic [ROWS*COLS-1:0] cpl_valid,
  output logic [ROWS*COLS-1:0] cpl_ready
);
  import matmul_pkg::*;

  count_t               total;
  logic [ROWS*COLS-1:0] lane_done;

  // Tiles each writer must report
  assign total = tiles_per_lane(job.len, N, ROWS, COLS);

  for (genvar p = 0; p < ROWS * COLS; p++) begin : g_writer
    count_t count;
    logic   finished;
    logic   hs;
    logic   last;

    assign cpl_ready[p] = job.active && !finished;
    assign hs           = cpl_valid[p] && cpl_ready[p];
    assign last         = (count == total - 1'b1);
    // Counts as done already on its final handshake
    assign lane_done[p] = finished || (hs && last);

    always_ff @(posedge clk) begin
      if (reset || !job.active) begin
        count    <= '0;
        finished <= 1'b0;
      end else if (hs) begin
        count    <= count + 1'b1;
        finished <= last;
      end
    end
  end

  assign job.all_done = &lane_done;

endmodule

//--- logic/tile_writer_issuer.sv
/*
 * C tile addresses, one lane per processor p = r*COLS + c
 * Lane p owns tiles (ii*ROWS + r, jj*COLS + c), walked row by row
 * C tiles are N*N words each, stored tile after tile
 */
`timescale 1ns/100ps

module tile_writer_issuer #(
  parameter int N    = 4,
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  job_if.issuer                             job,
  output logic [ROWS*COLS-1:0]              c_valid,
  input  logic [ROWS*COLS-1:0]              c_ready,
  output matmul_pkg::addr_t [ROWS*COLS-1:0] c_tile_addr
);
  import matmul_pkg::*;

  count_t tile_rows;
  count_t tile_cols;
  addr_t  row_step;
  addr_t  tile_step;

  assign tile_rows = strips_per_lane(job.len, N, ROWS);
  assign tile_cols = strips_per_lane(job.len, N, COLS);
  // ROWS tile rows further down
  assign row_step  = lane_offset(job.len, N, ROWS);
  // COLS tiles to the right
  assign tile_step = addr_t'(COLS * N * N);

  for (genvar p = 0; p < ROWS * COLS; p++) begin : g_proc
    localparam int lane_row = p / COLS;
    localparam int lane_col = p % COLS;

    logic   started;
    count_t ii;
    count_t jj;
    addr_t  row_base;
    addr_t  next_addr;
    logic   xfer;
    logic   wrap;

    assign c_valid[p]     = started && (ii != tile_rows);
    assign c_tile_addr[p] = next_addr;
    assign xfer           = c_valid[p] && c_ready[p];
    assign wrap           = (jj == tile_cols - 1'b1);

    always_ff @(posedge clk) begin
      if (reset || !job.active) begin
        started <= 1'b0;
        ii      <= '0;
        jj      <= '0;
      end else if (!started) begin
        started <= 1'b1;
      end else if (xfer) begin
        ii <= wrap ? ii + 1'b1 : ii;
        jj <= wrap ? '0 : jj + 1'b1;
      end
    end

    // Tile (lane_row, lane_col) first, then along its tile row
    always_ff @(posedge clk) begin
      if (job.active && !started) begin
        row_base  <= job.c_addr + lane_offset(job.len, N, lane_row) + addr_t'(lane_col * N * N);
        next_addr <= job.c_addr + lane_offset(job.len, N, lane_row) + addr_t'(lane_col * N * N);
      end else if (xfer && wrap) begin
        row_base  <= row_base + row_step;
        next_addr <= row_base + row_step;
      end else if (xfer) begin
        next_addr <= next_addr + tile_step;
      end
    end
  end

endmodule

//--- logic/b_strip_issuer.sv
/*
 * B strip instructions, one lane per processor column
 * B is stored transposed, so a column strip is contiguous
 * Lane c sweeps its T/COLS strips once per tile row of its processors
 */
`timescale 1ns/100ps

module b_strip_issuer #(
  parameter int N    = 4,
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                         clk,
  input  logic                         reset,
  job_if.issuer                        job,
  output logic [COLS-1:0]              b_valid,
  input  logic [COLS-1:0]              b_ready,
  output matmul_pkg::addr_t [COLS-1:0] b_strip_addr,
  output matmul_pkg::len_t             b_len
);
  import matmul_pkg::*;

  count_t inner;
  addr_t  step;

  // Strips per sweep and distance between strips of one lane
  assign inner = strips_per_lane(job.len, N, COLS);
  assign step  = lane_offset(job.len, N, COLS);
  assign b_len = job.len;

  for (genvar c = 0; c < COLS; c++) begin : g_col
    logic   started;
    count_t remaining;
    count_t jj;
    addr_t  first_addr;
    addr_t  next_addr;
    logic   xfer;
    logic   wrap;

    assign first_addr      = job.b_addr + lane_offset(job.len, N, c);
    assign b_valid[c]      = started && (remaining != '0);
    assign b_strip_addr[c] = next_addr;
    assign xfer            = b_valid[c] && b_ready[c];
    // Last strip of this sweep
    assign wrap            = (jj == inner - 1'b1);

    always_ff @(posedge clk) begin
      if (reset || !job.active) begin
        started   <= 1'b0;
        remaining <= '0;
        jj        <= '0;
      end else if (!started) begin
        started   <= 1'b1;
        remaining <= tiles_per_lane(job.len, N, ROWS, COLS);
        jj        <= '0;
      end else if (xfer) begin
        remaining <= remaining - 1'b1;
        jj        <= wrap ? '0 : jj + 1'b1;
      end
    end

    // Back to the lane's first strip on every wrap
    always_ff @(posedge clk) begin
      if (job.active && !started) begin
        next_addr <= first_addr;
      end else if (xfer) begin
        next_addr <= wrap ? first_addr : next_addr + step;
      end
    end
  end

endmodule

//--- logic/a_strip_issuer.sv
/*
 * A strip instructions, one lane per processor row
 * Lane r walks tile rows r, r+ROWS, ... of row-major A
 * Each strip is reused T/COLS times by its buffer
 */
`timescale 1ns/100ps

module a_strip_issuer #(
  parameter int N    = 4,
  parameter int ROWS = 2,
  parameter int COLS = 2
) (
  input  logic                          clk,
  input  logic                          reset,
  job_if.issuer                         job,
  output logic [ROWS-1:0]               a_valid,
  input  logic [ROWS-1:0]               a_ready,
  output matmul_pkg::addr_t [ROWS-1:0]  a_strip_addr,
  output matmul_pkg::count_t [ROWS-1:0] a_repeats,
  output matmul_pkg::len_t              a_len
);
  import matmul_pkg::*;

  addr_t step;

  // Next strip of a lane lies ROWS strips further down
  assign step  = lane_offset(job.len, N, ROWS);
  assign a_len = job.len;

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    logic   started;
    count_t remaining;
    addr_t  next_addr;
    count_t repeats;

    assign a_valid[r]      = started && (remaining != '0);
    assign a_strip_addr[r] = next_addr;
    assign a_repeats[r]    = repeats;

    // Lane control, loads one cycle after active rises
    always_ff @(posedge clk) begin
      if (reset || !job.active) begin
        started   <= 1'b0;
        remaining <= '0;
      end else if (!started) begin
        started   <= 1'b1;
        remaining <= strips_per_lane(job.len, N, ROWS);
      end else if (a_valid[r] && a_ready[r]) begin
        remaining <= remaining - 1'b1;
      end
    end

    // First strip is tile row r
    always_ff @(posedge clk) begin
      if (job.active && !started) begin
        next_addr <= job.a_addr + lane_offset(job.len, N, r);
        repeats   <= strips_per_lane(job.len, N, COLS);
      end else if (a_valid[r] && a_ready[r]) begin
        next_addr <= next_addr + step;
      end
    end
  end

endmodule

//--- logic/job_intake.sv
/*
 * Job intake, one job at a time
 * L is not checked here
 * done holds until the next job is accepted
 */
`timescale 1ns/100ps

module job_intake (
  input  logic              clk,
  input  logic              reset,
  input  logic              job_valid,
  output logic              job_ready,
  input  matmul_pkg::addr_t a_addr,
  input  matmul_pkg::addr_t b_addr,
  input  matmul_pkg::addr_t c_addr,
  input  matmul_pkg::len_t  matrix_len,
  output logic              done,
  job_if.intake             job
);

  logic accept;

  // Idle controller takes a new job
  assign job_ready = !job.active;
  assign accept    = job_valid && job_ready;

  // Busy and done state
  always_ff @(posedge clk) begin
    if (reset) begin
      job.active <= 1'b0;
      done       <= 1'b0;
    end else if (accept) begin
      job.active <= 1'b1;
      done       <= 1'b0;
    end else if (job.active && job.all_done) begin
      // Last tile written, back to idle
      job.active <= 1'b0;
      done       <= 1'b1;
    end
  end

  // Job fields, held for the whole job
  always_ff @(posedge clk) begin
    if (accept) begin
      job.a_addr <= a_addr;
      job.b_addr <= b_addr;
      job.c_addr <= c_addr;
      job.len    <= matrix_len;
    end
  end

endmodule

//--- logic/job_if.sv
/*
 * Latched job and its status, shared inside the controller
 * Fields are stable while active is high
 */
`timescale 1ns/100ps

interface job_if;
  import matmul_pkg::*;

  // Base addresses of A, B (stored transposed) and C
  addr_t a_addr;
  addr_t b_addr;
  addr_t c_addr;
  // Matrix edge L
  len_t  len;
  // High while a job is in flight
  logic  active;
  // Every writer has reported all its tiles
  logic  all_done;

  modport intake (output a_addr, b_addr, c_addr, len, active, input all_done);
  modport issuer (input a_addr, b_addr, c_addr, len, active);
  modport tracker (input len, active, output all_done);

endinterface

//--- logic/matmul_pkg.sv
/*
 * Widths, types and per-lane count helpers for the matmul job controller
 * L must be a nonzero multiple of N*ROWS and of N*COLS, and at most MAX_LEN
 * Counts assume (MAX_LEN/N)^2 fits in 16 bits
 */
package matmul_pkg;

  // Memory word address width
  localparam int ADDR_W = 32;
  // Largest matrix edge the controller handles
  localparam int MAX_LEN = 256;

  typedef logic [ADDR_W-1:0] addr_t;
  // Matrix length, 0 to MAX_LEN
  typedef logic [$clog2(MAX_LEN+1)-1:0] len_t;
  // Items or tiles per lane
  typedef logic [15:0] count_t;

  // Tile strips one lane owns along one side, (L/n)/lanes
  function automatic count_t strips_per_lane(len_t len, int unsigned n, int unsigned lanes);
    return count_t'((len / n) / lanes);
  endfunction

  // Tiles one processor owns, also the writer's completion count
  function automatic count_t tiles_per_lane(len_t len, int unsigned n, int unsigned rows,
                                            int unsigned cols);
    return count_t'(strips_per_lane(len, n, rows) * strips_per_lane(len, n, cols));
  endfunction

  // k strips of n full rows, k*n*L words
  function automatic addr_t lane_offset(len_t len, int unsigned n, int unsigned k);
    return addr_t'(k) * addr_t'(n) * addr_t'(len);
  endfunction

endpackage
